//--- src/approx_counter.sv
`timescale 1ns/1ns

module approx_counter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clear,
    input  lincount_pkg::sample_t             pt,
    input  logic [63:0]                       ct,
    output logic [lincount_pkg::COUNT_W-1:0]  count
);
    import lincount_pkg::*;

    logic pt_par;
    logic ct_par;
    logic match_valid;  // Second stage
    logic match_q;

    assign pt_par = ^(pt.data & MASK_IN);
    assign ct_par = ^(ct & MASK_OUT);

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            match_valid <= 1'b0;
            match_q     <= 1'b0;
            count       <= '0;
        end else begin
            match_valid <= pt.valid;
            match_q     <= (pt_par == ct_par);
            if (match_valid && match_q)
                count <= count + 1'b1;  // Approximation holds for this sample
        end
    end

endmodule

//--- src/feistel_cipher.sv
`timescale 1ns/1ns

module feistel_cipher (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lincount_pkg::sample_t  pt_in,
    output lincount_pkg::sample_t  pt_out,
    output logic [63:0]            ct_out
);
    import lincount_pkg::*;

    logic [ROUNDS:0][31:0] l_half;
    logic [ROUNDS:0][31:0] r_half;
    logic                  valid_q;
    logic [63:0]           pt_q;

    // Rotate-left-5 of (r ^ k), mixed with the modular sum
    function automatic logic [31:0] round_f(input logic [31:0] r, input logic [31:0] k);
        logic [31:0] x;
        x = r ^ k;
        return {x[26:0], x[31:27]} ^ (r + k);
    endfunction

    always_comb begin
        l_half[0] = pt_in.data[63:32];
        r_half[0] = pt_in.data[31:0];
        for (int i = 0; i < ROUNDS; i++) begin
            l_half[i+1] = r_half[i];
            r_half[i+1] = l_half[i] ^ round_f(r_half[i], ROUND_KEYS[i]);
        end
    end

    // First pipeline stage
    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= pt_in.valid;
    end

    always_ff @(posedge clk) begin
        pt_q   <= pt_in.data;
        ct_out <= {l_half[ROUNDS], r_half[ROUNDS]};
    end

    assign pt_out = '{valid: valid_q, data: pt_q};

endmodule

//--- src/lincount_pkg.sv
package lincount_pkg;

    localparam int SAMPLE_COUNT = 1024;  // Samples per run
    localparam int COUNT_W      = 32;
    localparam int ROUNDS       = 4;

    // Fixed cipher key, one word per round
    localparam logic [ROUNDS-1:0][31:0] ROUND_KEYS = {
        32'h5a17_c3e9,  // Round 3
        32'h0f1e_2d3c,  // Round 2
        32'hb7e1_5163,  // Round 1
        32'h9e37_79b9   // Round 0
    };

    // Linear approximation masks
    localparam logic [63:0] MASK_IN  = 64'h2104008000000000;
    localparam logic [63:0] MASK_OUT = 64'h0000000021040080;

    // Bus word addresses
    localparam logic [2:0] ADDR_DATA_LO = 3'd0;
    localparam logic [2:0] ADDR_DATA_HI = 3'd1;
    localparam logic [2:0] ADDR_CMD     = 3'd2;
    localparam logic [2:0] ADDR_STATUS  = 3'd3;
    localparam logic [2:0] ADDR_COUNT   = 3'd4;

    typedef enum logic [3:0] {
        OP_NONE      = 4'h0,  // Reset value of last_op
        OP_LOAD_SEED = 4'h1,
        OP_LOAD_POLY = 4'h2,
        OP_START     = 4'h3,
        OP_RESTART   = 4'h5
    } cmd_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } ctrl_state_e;

    typedef struct packed {
        logic        valid;
        cmd_op_e     op;
        logic [63:0] operand;  // {DATA_HI, DATA_LO}
    } cmd_req_t;

    typedef struct packed {
        logic    busy;
        logic    done;
        cmd_op_e last_op;
    } ctrl_status_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } sample_t;

endpackage

//--- src/lincount_top.sv
`timescale 1ns/1ns

module lincount_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [2:0]  adr,
    input  logic [31:0] dat_w,
    output logic        ack,
    output logic [31:0] dat_r
);
    import lincount_pkg::*;

    cmd_req_t            cmd_req;
    ctrl_status_t        status;
    logic [COUNT_W-1:0]  count;
    logic [63:0]         seed;
    logic [63:0]         poly;
    logic                lfsr_load;
    logic                lfsr_step;
    logic                count_clear;
    sample_t             pt_sample;  // Straight from the LFSR
    sample_t             pt_stage;   // Aligned with ct_stage
    logic [63:0]         ct_stage;

    wb_cmd_port u_port (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .status(status), .count(count),
        .ack(ack), .dat_r(dat_r), .cmd_req(cmd_req)
    );

    search_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .status(status),
        .seed(seed), .poly(poly), .lfsr_load(lfsr_load), .lfsr_step(lfsr_step),
        .count_clear(count_clear)
    );

    plaintext_lfsr u_lfsr (
        .clk(clk), .rst_n(rst_n), .load(lfsr_load), .step(lfsr_step),
        .seed(seed), .poly(poly), .sample(pt_sample)
    );

    feistel_cipher u_cipher (
        .clk(clk), .rst_n(rst_n), .pt_in(pt_sample), .pt_out(pt_stage), .ct_out(ct_stage)
    );

    approx_counter u_counter (
        .clk(clk), .rst_n(rst_n), .clear(count_clear), .pt(pt_stage), .ct(ct_stage),
        .count(count)
    );

endmodule

//--- src/plaintext_lfsr.sv
`timescale 1ns/1ns

module plaintext_lfsr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  logic                   step,
    input  logic [63:0]            seed,
    input  logic [63:0]            poly,
    output lincount_pkg::sample_t  sample
);

    logic [63:0] lfsr;
    logic [63:0] lfsr_next;

    // Galois form, shift right with feedback on the outgoing bit
    assign lfsr_next = {1'b0, lfsr[63:1]} ^ (lfsr[0] ? poly : 64'h0);

    always_ff @(posedge clk) begin
        if (!rst_n)
            lfsr <= 64'h0;
        else if (load)
            lfsr <= seed;
        else if (step)
            lfsr <= lfsr_next;
    end

    // Plaintext is the state before the step
    assign sample = '{valid: step, data: lfsr};

endmodule

//--- src/search_ctrl.sv
`timescale 1ns/1ns

module search_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  lincount_pkg::cmd_req_t      cmd_req,
    output lincount_pkg::ctrl_status_t  status,
    output logic [63:0]                 seed,
    output logic [63:0]                 poly,
    output logic                        lfsr_load,
    output logic                        lfsr_step,
    output logic                        count_clear
);
    import lincount_pkg::*;

    ctrl_state_e                      state;
    cmd_op_e                          last_op;
    logic [$clog2(SAMPLE_COUNT)-1:0]  step_cnt;  // Also counts drain cycles
    logic                             accept;
    logic                             start_acc;
    logic                             restart_acc;

    // Command filter by state
    always_comb begin
        accept = 1'b0;
        if (cmd_req.valid) begin
            case (cmd_req.op)
                OP_LOAD_SEED, OP_LOAD_POLY, OP_START: accept = (state == ST_IDLE);
                OP_RESTART:                           accept = 1'b1;
                default:                              accept = 1'b0;
            endcase
        end
    end

    assign start_acc   = accept && (cmd_req.op == OP_START);
    assign restart_acc = accept && (cmd_req.op == OP_RESTART);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            last_op  <= OP_NONE;
            step_cnt <= '0;
        end else begin
            if (accept)
                last_op <= cmd_req.op;
            if (restart_acc) begin
                state <= ST_IDLE;  // Abort or clear, from any state
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (start_acc) begin
                            state    <= ST_RUN;
                            step_cnt <= '0;
                        end
                    end
                    ST_RUN: begin
                        step_cnt <= step_cnt + 1'b1;
                        if (step_cnt == SAMPLE_COUNT - 1) begin
                            state    <= ST_DRAIN;
                            step_cnt <= '0;
                        end
                    end
                    ST_DRAIN: begin  // Two cycles to empty cipher and match stages
                        step_cnt <= step_cnt + 1'b1;
                        if (step_cnt == 1)
                            state <= ST_DONE;
                    end
                    ST_DONE: ;       // Hold until restart
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Operand latches
    always_ff @(posedge clk) begin
        if (accept && (cmd_req.op == OP_LOAD_SEED))
            seed <= cmd_req.operand;
        if (accept && (cmd_req.op == OP_LOAD_POLY))
            poly <= cmd_req.operand;
    end

    assign lfsr_load   = start_acc;
    // No new sample on the restart edge, so the count stays clear
    assign lfsr_step   = (state == ST_RUN) && !restart_acc;
    assign count_clear = start_acc || restart_acc;

    assign status = '{
        busy:    (state == ST_RUN) || (state == ST_DRAIN),
        done:    (state == ST_DONE),
        last_op: last_op
    };

endmodule

//--- src/wb_cmd_port.sv
`timescale 1ns/1ns

module wb_cmd_port (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [2:0]                        adr,
    input  logic [31:0]                       dat_w,
    input  lincount_pkg::ctrl_status_t        status,
    input  logic [lincount_pkg::COUNT_W-1:0]  count,
    output logic                              ack,
    output logic [31:0]                       dat_r,
    output lincount_pkg::cmd_req_t            cmd_req
);
    import lincount_pkg::*;

    logic        xfer;         // New transfer, ack not yet given
    logic [31:0] data_lo;
    logic [31:0] data_hi;
    logic        cmd_valid_q;
    cmd_op_e     cmd_op_q;

    assign xfer = cyc && stb && !ack;

    // One ack cycle per transfer, command pulse lines up with it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            cmd_valid_q <= 1'b0;
        end else begin
            ack         <= xfer;
            cmd_valid_q <= xfer && we && (adr == ADDR_CMD);
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && we) begin
            case (adr)
                ADDR_DATA_LO: data_lo <= dat_w;
                ADDR_DATA_HI: data_hi <= dat_w;
                ADDR_CMD:     cmd_op_q <= cmd_op_e'(dat_w[3:0]);  // Unknown codes pass through
                default: ;
            endcase
        end
    end

    assign cmd_req = '{valid: cmd_valid_q, op: cmd_op_q, operand: {data_hi, data_lo}};

    // Read mux, master holds adr through the ack cycle
    always_comb begin
        case (adr)
            ADDR_DATA_LO: dat_r = data_lo;
            ADDR_DATA_HI: dat_r = data_hi;
            ADDR_STATUS:  dat_r = {24'h0, status.last_op, 2'b00, status.done, status.busy};
            ADDR_COUNT:   dat_r = count;
            default:      dat_r = 32'h0;
        endcase
    end

endmodule

//--- verification/lincount_asserts.sv
`timescale 1ns/1ns

module lincount_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        cyc,
    input logic                        stb,
    input logic                        ack,
    input lincount_pkg::ctrl_status_t  status
);

    // Ack is only an answer to a request seen on the previous edge
    ack_after_request: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $past(cyc && stb))
        else $error("ack raised without a preceding cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack)
        else $error("ack held high for two cycles");

    busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(status.busy && status.done))
        else $error("busy and done high together");

endmodule

bind wb_cmd_port lincount_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .ack(ack), .status(status)
);

//--- verification/lincount_tb.sv
`timescale 1ns/1ns

module lincount_tb;
    import lincount_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat_w;
    logic        ack;
    logic [31:0] dat_r;

    logic [31:0] lcg_state;
    string       name_q[$];  // Pending checks, compared in order
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    event        check_ev;
    string       cur_name;
    logic [31:0] cur_exp;
    logic [31:0] cur_act;

    lincount_top uut (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .ack(ack), .dat_r(dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected STATUS word
    function automatic logic [31:0] status_word(input logic busy, input logic done,
                                                input logic [3:0] op);
        return {24'h0, op, 2'b00, done, busy};
    endfunction

    // Software model of one full run
    function automatic logic [31:0] ref_count(input logic [63:0] seed, input logic [63:0] poly);
        logic [63:0] state;
        logic [63:0] ct;
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] x;
        logic [31:0] f;
        logic [31:0] t;
        logic [31:0] n;
        state = seed;
        n = 32'd0;
        for (int s = 0; s < SAMPLE_COUNT; s++) begin
            l = state[63:32];
            r = state[31:0];
            for (int i = 0; i < ROUNDS; i++) begin
                x = r ^ ROUND_KEYS[i];
                f = ((x << 5) | (x >> 27)) ^ (r + ROUND_KEYS[i]);
                t = r;
                r = l ^ f;
                l = t;
            end
            ct = {l, r};
            if ((^(state & MASK_IN)) == (^(ct & MASK_OUT)))
                n = n + 32'd1;
            state = (state >> 1) ^ (state[0] ? poly : 64'h0);
        end
        return n;
    endfunction

    task automatic wb_write(input logic [2:0] a, input logic [31:0] d);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        do @(negedge clk); while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] a, output logic [31:0] d);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        do @(negedge clk); while (!ack);
        d = dat_r;  // Valid during the ack cycle
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic load_operand(input logic [63:0] v, input logic [3:0] op);
        wb_write(ADDR_DATA_LO, v[31:0]);
        wb_write(ADDR_DATA_HI, v[63:32]);
        wb_write(ADDR_CMD, {28'h0, op});
    endtask

    task automatic wait_done();
        logic [31:0] st;
        do wb_read(ADDR_STATUS, st); while (!st[1]);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        -> check_ev;
    endtask

    task automatic run_and_check(input string name, input logic [63:0] s,
                                 input logic [63:0] p);
        logic [31:0] rd;
        load_operand(s, OP_LOAD_SEED);
        load_operand(p, OP_LOAD_POLY);
        wb_write(ADDR_CMD, {28'h0, OP_START});
        wait_done();
        wb_read(ADDR_COUNT, rd);
        check_value(name, ref_count(s, p), rd);
    endtask

    // Compare process
    initial begin
        forever begin
            @(check_ev);
            while (exp_q.size() > 0) begin
                cur_name = name_q.pop_front();
                cur_exp  = exp_q.pop_front();
                cur_act  = act_q.pop_front();
                assert (cur_act === cur_exp) else begin
                    $display("MISMATCH %s expected %h actual %h", cur_name, cur_exp, cur_act);
                    $display("test failed");
                    $fatal(1);
                end
            end
        end
    end

    initial begin
        repeat (6 * (SAMPLE_COUNT + 50)) @(posedge clk);
        $display("Timeout, the DUT never finished the test sequence");
        $display("test failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] rd;
        logic [63:0] s0;
        logic [63:0] p0;
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = 3'd0;
        dat_w = 32'h0;
        lcg_state = 32'hcf46_eb99;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        wb_read(ADDR_STATUS, rd);
        check_value("reset_status", 32'h0, rd);
        wb_read(ADDR_COUNT, rd);
        check_value("reset_count", 32'h0, rd);
        wb_write(ADDR_DATA_LO, 32'h1234_5678);
        wb_write(ADDR_DATA_HI, 32'h9abc_def0);
        wb_read(ADDR_DATA_LO, rd);
        check_value("data_lo_readback", 32'h1234_5678, rd);
        wb_read(ADDR_DATA_HI, rd);
        check_value("data_hi_readback", 32'h9abc_def0, rd);
        wb_read(3'd5, rd);
        check_value("unmapped_read", 32'h0, rd);

        // Fixed run, busy seen before done
        load_operand(64'h0123_4567_89ab_cdef, OP_LOAD_SEED);
        load_operand(64'hd800_0000_0000_0000, OP_LOAD_POLY);
        wb_write(ADDR_CMD, {28'h0, OP_START});
        wb_read(ADDR_STATUS, rd);
        check_value("fixed_busy", status_word(1, 0, OP_START), rd);
        wait_done();
        wb_read(ADDR_STATUS, rd);
        check_value("fixed_done", status_word(0, 1, OP_START), rd);
        wb_read(ADDR_COUNT, rd);
        check_value("fixed_count", ref_count(64'h0123_4567_89ab_cdef, 64'hd800_0000_0000_0000), rd);

        for (int k = 0; k < 2; k++) begin  // Random runs
            wb_write(ADDR_CMD, {28'h0, OP_RESTART});
            wb_read(ADDR_STATUS, rd);
            check_value("restart_status", status_word(0, 0, OP_RESTART), rd);
            s0 = {lcg_next(), lcg_next()};
            p0 = {lcg_next(), lcg_next()} | 64'h8000_0000_0000_0000;
            run_and_check("random_count", s0, p0);
        end

        // Abort a run in flight
        wb_write(ADDR_CMD, {28'h0, OP_RESTART});
        wb_write(ADDR_CMD, {28'h0, OP_START});
        wb_read(ADDR_STATUS, rd);
        check_value("abort_busy", status_word(1, 0, OP_START), rd);
        wb_write(ADDR_CMD, {28'h0, OP_RESTART});
        wb_read(ADDR_STATUS, rd);
        check_value("abort_status", status_word(0, 0, OP_RESTART), rd);
        wb_read(ADDR_COUNT, rd);
        check_value("abort_count", 32'h0, rd);

        // Refused and unknown commands
        s0 = {lcg_next(), lcg_next()};
        p0 = {lcg_next(), lcg_next()} | 64'h8000_0000_0000_0000;
        load_operand(s0, OP_LOAD_SEED);
        load_operand(p0, OP_LOAD_POLY);
        wb_write(ADDR_CMD, 32'h7);
        wb_read(ADDR_STATUS, rd);
        check_value("unknown_op", status_word(0, 0, OP_LOAD_POLY), rd);
        wb_write(ADDR_CMD, {28'h0, OP_START});
        load_operand({lcg_next(), lcg_next()}, OP_LOAD_SEED);
        load_operand({lcg_next(), lcg_next()}, OP_LOAD_POLY);
        wb_write(ADDR_CMD, {28'h0, OP_START});
        wb_read(ADDR_STATUS, rd);
        check_value("busy_ignore", status_word(1, 0, OP_START), rd);
        wait_done();
        wb_write(ADDR_CMD, {28'h0, OP_LOAD_SEED});
        wb_write(ADDR_CMD, {28'h0, OP_START});
        wb_read(ADDR_STATUS, rd);
        check_value("done_ignore", status_word(0, 1, OP_START), rd);
        wb_read(ADDR_COUNT, rd);
        check_value("ignore_count", ref_count(s0, p0), rd);

        @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

//--- vlog.f
src/lincount_pkg.sv
src/wb_cmd_port.sv
src/search_ctrl.sv
src/plaintext_lfsr.sv
src/feistel_cipher.sv
src/approx_counter.sv
src/lincount_top.sv
verification/lincount_asserts.sv
verification/lincount_tb.sv
